/* flist.f */
hw/rxbuf_geom_pkg.sv
hw/rxbuf_frame_pkg.sv
hw/rxbuf_word_ram.sv
hw/rxbuf_frame_store.sv
hw/rxbuf_byte_framer.sv
hw/rxbuf_frame_reader.sv
hw/rxbuf_top.sv
tests/rxbuf_checker.sv
tests/rxbuf_tb.sv

/* hw/rxbuf_byte_framer.sv */
// in_end must come at least one cycle after the last byte; a byte in the same cycle as in_end is lost
`default_nettype none
`timescale 1ns/1ps

module rxbuf_byte_framer
    import rxbuf_geom_pkg::*;
    import rxbuf_frame_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,

    input  wire logic [7:0] in_byte,
    input  wire logic       in_valid,
    input  wire logic       in_end,
    input  wire logic       in_err,

    output frame_wr_t       wr,
    output logic            commit,
    output frame_status_t   commit_status
);

    frame_off_t cnt;        // offset of the next byte
    logic       started;    // at least one byte seen
    logic       full;       // 256 bytes taken, cnt has wrapped
    logic       too_long;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr            <= '0;
            commit        <= 1'b0;
            commit_status <= '0;
            cnt           <= '0;
            started       <= 1'b0;
            full          <= 1'b0;
            too_long      <= 1'b0;
        end else begin
            wr.en  <= 1'b0;
            commit <= 1'b0;

            if (in_end) begin
                if (started) begin
                    commit            <= 1'b1;
                    commit_status.len <= cnt - frame_off_t'(1);     // 256 bytes give ff
                    commit_status.err <= in_err || too_long;
                end
                cnt      <= '0;
                started  <= 1'b0;
                full     <= 1'b0;
                too_long <= 1'b0;
            end else if (in_valid) begin
                started <= 1'b1;
                if (full) begin
                    too_long <= 1'b1;           // clipped, byte is dropped
                end else begin
                    wr.en   <= 1'b1;
                    wr.off  <= cnt;
                    wr.data <= in_byte;
                    cnt     <= cnt + frame_off_t'(1);
                    if (cnt == frame_off_t'(8'hff)) begin
                        full <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rxbuf_frame_pkg.sv */
// bus structs between framer, store and reader; len fields hold the frame length minus one
`default_nettype none

package rxbuf_frame_pkg;
    import rxbuf_geom_pkg::*;

    // one byte from the framer, en is the strobe
    typedef struct packed {
        logic [7:0] data;
        frame_off_t off;
        logic       en;
    } frame_wr_t;

    typedef struct packed {
        frame_len_t len;
        logic       err;
    } frame_status_t;

    // data bytes are little-endian, unused upper lanes of the last word are zero
    typedef struct packed {
        buf_word_t  data;
        logic       first;
        logic       last;
        logic       err;
        frame_len_t len;
    } frame_word_t;

endpackage

`default_nettype wire

/* hw/rxbuf_frame_reader.sv */
// drain_en is only sampled between frames; a frame once started is always read to its end unless flushed
`default_nettype none
`timescale 1ns/1ps

module rxbuf_frame_reader
    import rxbuf_geom_pkg::*;
    import rxbuf_frame_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset_n,

    input  wire logic          drain_en,
    input  wire logic          flush,
    input  wire logic          unread,
    input  wire frame_status_t rd_status,

    output logic               rd_en,
    output word_off_t          rd_off,
    input  wire buf_word_t     rd_data,
    output logic               rd_release,

    output frame_word_t        out_word,
    output logic               out_valid
);

    typedef enum logic [1:0] {
        idle,
        read,
        releasing,
        settle
    } reader_state_t;

    reader_state_t state;
    word_off_t     last_off;    // index of the frame's final word
    frame_status_t cur;         // status latched at frame start
    logic          settle_cnt;
    logic          rd_first;    // tags of the read issued this cycle
    logic          rd_last;
    logic          ret_valid;   // tags of the word now on rd_data
    logic          ret_first;
    logic          ret_last;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= idle;
            rd_en      <= 1'b0;
            rd_off     <= '0;
            rd_release <= 1'b0;
            rd_first   <= 1'b0;
            rd_last    <= 1'b0;
            last_off   <= '0;
            cur        <= '0;
            settle_cnt <= 1'b0;
        end else if (flush) begin
            // settle lets the cleared unread flag reach us
            state      <= settle;
            rd_en      <= 1'b0;
            rd_release <= 1'b0;
            rd_first   <= 1'b0;
            rd_last    <= 1'b0;
            settle_cnt <= 1'b0;
        end else begin
            rd_release <= 1'b0;
            case (state)
                idle: begin
                    if (drain_en && unread) begin
                        state    <= read;
                        rd_en    <= 1'b1;
                        rd_off   <= '0;
                        rd_first <= 1'b1;
                        rd_last  <= (rd_status.len[7:2] == '0);
                        last_off <= word_off_t'(rd_status.len[7:2]);
                        cur      <= rd_status;
                    end
                end
                read: begin
                    rd_first <= 1'b0;
                    if (rd_off == last_off) begin
                        rd_en   <= 1'b0;
                        rd_last <= 1'b0;
                        state   <= releasing;
                    end else begin
                        rd_off  <= rd_off + word_off_t'(1);
                        rd_last <= (rd_off + word_off_t'(1) == last_off);
                    end
                end
                releasing: begin
                    rd_release <= 1'b1;
                    settle_cnt <= 1'b0;
                    state      <= settle;
                end
                default: begin
                    settle_cnt <= 1'b1;
                    if (settle_cnt) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ret_valid <= 1'b0;
            ret_first <= 1'b0;
            ret_last  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            ret_valid <= rd_en && !flush;
            ret_first <= rd_first;
            ret_last  <= rd_last;
            out_valid <= ret_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        out_word <= '{data: rd_data, first: ret_first, last: ret_last,
                      err: cur.err, len: cur.len};
    end

endmodule

`default_nettype wire

/* hw/rxbuf_frame_store.sv */
// no back-pressure; a frame that runs into an unread block is cancelled and reported by drop at commit
`default_nettype none
`timescale 1ns/1ps

module rxbuf_frame_store
    import rxbuf_geom_pkg::*;
    import rxbuf_frame_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          reset_n,

    input  wire frame_wr_t     wr,
    input  wire logic          commit,
    input  wire frame_status_t commit_status,
    input  wire logic          flush,
    output logic               drop,

    input  wire logic          rd_en,
    input  wire word_off_t     rd_off,
    output buf_word_t          rd_data,
    output logic               unread,
    output frame_status_t      rd_status,
    input  wire logic          rd_release
);

    typedef struct packed {
        frag_cnt_t  frag;
        frame_len_t len;
    } idx_entry_t;

    blk_idx_t               wr_ptr;
    blk_idx_t               rd_ptr;
    logic [2**idx_width-1:0] dirty;      // head block of an unread frame
    logic [2**idx_width-1:0] err_flag;
    idx_entry_t             idx_table [2**idx_width];
    frag_cnt_t              rd_frag;     // extra blocks of the frame at rd_ptr

    logic                   cancel;
    logic                   commit_d;
    frame_status_t          commit_stat_d;
    frag_cnt_t              commit_frag;

    blk_idx_t               wr_base;
    blk_idx_t               wr_blk;
    logic                   cancel_eff;
    logic                   byte_ok;

    logic                   word_we;
    word_addr_t             word_waddr;
    buf_word_t              asm_word;
    word_addr_t             word_raddr;

    assign commit_frag = frag_cnt_t'(commit_stat_d.len[$bits(frame_len_t)-1:blk_width]);

    // a byte of the next frame may land while the previous commit is still pending
    assign wr_base    = (commit_d && !cancel) ?
                        wr_ptr + blk_idx_t'(commit_frag) + blk_idx_t'(1) : wr_ptr;
    assign cancel_eff = cancel && !commit_d;
    assign wr_blk     = wr_base + blk_idx_t'(wr.off[$bits(frame_off_t)-1:blk_width]);
    assign byte_ok    = wr.en && !cancel_eff && !dirty[wr_blk];

    assign word_raddr = word_addr_t'({rd_ptr, {(blk_width-2){1'b0}}}) + word_addr_t'(rd_off);

    always_ff @(posedge clk) begin
        if (commit) begin
            commit_stat_d <= commit_status;
        end
    end

    // byte lanes are filled in order, the partial word is rewritten with every byte
    always_ff @(posedge clk) begin
        if (byte_ok) begin
            word_waddr <= word_addr_t'({wr_base, {(blk_width-2){1'b0}}}) +
                          word_addr_t'(wr.off[$bits(frame_off_t)-1:2]);
            case (wr.off[1:0])
                2'd0:    asm_word        <= {24'h0, wr.data};
                2'd1:    asm_word[15:8]  <= wr.data;
                2'd2:    asm_word[23:16] <= wr.data;
                default: asm_word[31:24] <= wr.data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (commit_d && !cancel) begin
            idx_table[wr_ptr] <= '{frag: commit_frag, len: commit_stat_d.len};
        end
    end

    // status toward the reader lags the read pointer by one cycle
    always_ff @(posedge clk) begin
        rd_frag       <= idx_table[rd_ptr].frag;
        rd_status.len <= idx_table[rd_ptr].len;
        rd_status.err <= err_flag[rd_ptr];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            dirty    <= '0;
            err_flag <= '0;
            cancel   <= 1'b0;
            commit_d <= 1'b0;
            drop     <= 1'b0;
            word_we  <= 1'b0;
            unread   <= 1'b0;
        end else begin
            drop     <= 1'b0;
            commit_d <= commit;
            word_we  <= byte_ok;
            unread   <= dirty[rd_ptr];

            if (rd_release && dirty[rd_ptr]) begin
                dirty[rd_ptr] <= 1'b0;
                rd_ptr        <= rd_ptr + blk_idx_t'(rd_frag) + blk_idx_t'(1);
            end

            if (commit_d) begin
                cancel <= 1'b0;
                if (cancel) begin
                    drop <= 1'b1;               // frame overran unread data
                end else begin
                    dirty[wr_ptr]    <= 1'b1;
                    err_flag[wr_ptr] <= commit_stat_d.err;
                    wr_ptr           <= wr_base;
                end
            end

            if (wr.en && !cancel_eff && dirty[wr_blk]) begin
                cancel <= 1'b1;                 // rest of this frame is ignored
            end

            if (flush) begin
                wr_ptr   <= '0;
                rd_ptr   <= '0;
                dirty    <= '0;
                cancel   <= 1'b0;
                commit_d <= 1'b0;
                drop     <= 1'b0;
                unread   <= 1'b0;
            end
        end
    end

    rxbuf_word_ram u_ram (
        .clk     (clk),
        .wr_en   (word_we),
        .wr_addr (word_waddr),
        .wr_data (asm_word),
        .rd_en   (rd_en),
        .rd_addr (word_raddr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* hw/rxbuf_geom_pkg.sv */
// ring geometry is fixed at 64 blocks of 32 bytes; frames are 1 to 256 bytes, at most 8 blocks
`default_nettype none

package rxbuf_geom_pkg;

    localparam int idx_width       = 6;                   // 64 blocks
    localparam int buf_width       = 11;                  // 2048 bytes
    localparam int blk_width       = buf_width - idx_width; // 32 bytes per block
    localparam int frag_width      = 3;                   // up to 7 extra blocks
    localparam int word_addr_width = buf_width - 2;       // 512 words of 32 bits

    typedef logic [idx_width-1:0]       blk_idx_t;
    typedef logic [7:0]                 frame_len_t;      // length minus one
    typedef logic [7:0]                 frame_off_t;      // byte offset in frame
    typedef logic [5:0]                 word_off_t;       // word offset in frame
    typedef logic [frag_width-1:0]      frag_cnt_t;
    typedef logic [31:0]                buf_word_t;
    typedef logic [word_addr_width-1:0] word_addr_t;

endpackage

`default_nettype wire

/* hw/rxbuf_top.sv */
// no back-pressure on out_valid; with drain_en low frames queue until the 64-block ring is full
`default_nettype none
`timescale 1ns/1ps

module rxbuf_top
    import rxbuf_geom_pkg::*;
    import rxbuf_frame_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  wire logic [7:0] in_byte,
    input  wire logic       in_valid,
    input  wire logic       in_end,
    input  wire logic       in_err,
    input  wire logic       flush,
    input  wire logic       drain_en,
    output frame_word_t     out_word,
    output logic            out_valid,
    output logic            drop
);

    frame_wr_t     wr;
    logic          commit;
    frame_status_t commit_status;
    logic          rd_en;
    word_off_t     rd_off;
    buf_word_t     rd_data;
    logic          unread;
    frame_status_t rd_status;
    logic          rd_release;

    rxbuf_byte_framer u_framer (
        .clk           (clk),
        .reset_n       (reset_n),
        .in_byte       (in_byte),
        .in_valid      (in_valid),
        .in_end        (in_end),
        .in_err        (in_err),
        .wr            (wr),
        .commit        (commit),
        .commit_status (commit_status)
    );

    rxbuf_frame_store u_store (
        .clk           (clk),
        .reset_n       (reset_n),
        .wr            (wr),
        .commit        (commit),
        .commit_status (commit_status),
        .flush         (flush),
        .drop          (drop),
        .rd_en         (rd_en),
        .rd_off        (rd_off),
        .rd_data       (rd_data),
        .unread        (unread),
        .rd_status     (rd_status),
        .rd_release    (rd_release)
    );

    rxbuf_frame_reader u_reader (
        .clk        (clk),
        .reset_n    (reset_n),
        .drain_en   (drain_en),
        .flush      (flush),
        .unread     (unread),
        .rd_status  (rd_status),
        .rd_en      (rd_en),
        .rd_off     (rd_off),
        .rd_data    (rd_data),
        .rd_release (rd_release),
        .out_word   (out_word),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

/* hw/rxbuf_word_ram.sv */
// read data is registered and only updates on rd_en; read and write of one address in a cycle return old data
`default_nettype none
`timescale 1ns/1ps

module rxbuf_word_ram
    import rxbuf_geom_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       wr_en,
    input  wire word_addr_t wr_addr,
    input  wire buf_word_t  wr_data,
    input  wire logic       rd_en,
    input  wire word_addr_t rd_addr,
    output buf_word_t       rd_data
);

    buf_word_t mem [2**word_addr_width];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];    // one cycle read latency
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module rxbuf_tb -f flist.f -o rxbuf_sim &&
    ./obj_dir/rxbuf_sim 2>&1 | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
    echo "simulation run passed" ||
    { echo "simulation run failed"; exit 1; }

/* tests/rxbuf_checker.sv */
// sampled on the rising clock and idle in reset; inputs that a bound module lacks are tied low
`default_nettype none
`timescale 1ns/1ps

module rxbuf_checker (
    input wire logic clk,
    input wire logic reset_n,
    input wire logic flush,
    input wire logic commit,
    input wire logic drop,
    input wire logic rd_release,
    input wire logic out_valid
);

    commit_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        commit |-> !$past(commit))
        else $error("commit stayed high for more than one cycle");

    release_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        rd_release |-> !$past(rd_release))
        else $error("release stayed high for more than one cycle");

    // drop reports the commit of a cancelled frame
    drop_after_commit: assert property (@(posedge clk) disable iff (!reset_n)
        drop |-> $past(commit, 2))
        else $error("drop without a commit two cycles before");

    quiet_after_flush: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> !$past(flush) && !$past(flush, 2))
        else $error("output word within two cycles of flush");

endmodule

bind rxbuf_frame_store rxbuf_checker u_store_chk (
    .clk        (clk),
    .reset_n    (reset_n),
    .flush      (flush),
    .commit     (commit),
    .drop       (drop),
    .rd_release (rd_release),
    .out_valid  (1'b0)
);

bind rxbuf_frame_reader rxbuf_checker u_reader_chk (
    .clk        (clk),
    .reset_n    (reset_n),
    .flush      (flush),
    .commit     (1'b0),
    .drop       (1'b0),
    .rd_release (rd_release),
    .out_valid  (out_valid)
);

`default_nettype wire

/* tests/rxbuf_tb.sv */
// frames are sent one at a time with a gap; unused upper byte lanes of a last word are expected as zero
`default_nettype none
`timescale 1ns/1ps

module rxbuf_tb
    import rxbuf_geom_pkg::*;
    import rxbuf_frame_pkg::*;
();

    logic        clk;
    logic        reset_n;
    logic [7:0]  in_byte;
    logic        in_valid;
    logic        in_end;
    logic        in_err;
    logic        flush;
    logic        drain_en;
    frame_word_t out_word;
    logic        out_valid;
    logic        drop;

    integer      seed;
    int          err_cnt;
    int          cycle_cnt;
    int          bytes_sent;
    int          drop_cnt;
    int          exp_drops;
    int          ring_used;         // blocks held by unread frames while draining is off
    logic [7:0]  exp_data [$];      // kept bytes of every frame sent
    int          exp_n_q [$];       // expected frames, oldest first
    logic        exp_err_q [$];
    int          exp_base_q [$];
    int          cur_n;             // 0 between frames
    int          cur_base;
    int          cur_w;
    logic        cur_err;

    rxbuf_top u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_byte   (in_byte),
        .in_valid  (in_valid),
        .in_end    (in_end),
        .in_err    (in_err),
        .flush     (flush),
        .drain_en  (drain_en),
        .out_word  (out_word),
        .out_valid (out_valid),
        .drop      (drop)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input buf_word_t got, input buf_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_len(input string name, input frame_len_t got, input frame_len_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            err_cnt++;
            stop_run();
        end
    endtask

    function automatic int blocks_of(input int n);
        return (n + 31) / 32;
    endfunction

    function automatic buf_word_t expected_word(input int base, input int n, input int w);
        buf_word_t word;
        word = '0;
        for (int b = 0; b < 4; b++) begin
            if (w * 4 + b < n) begin
                word[b*8 +: 8] = exp_data[base + w * 4 + b];    // little-endian lanes
            end
        end
        return word;
    endfunction

    function automatic int rand_len();
        return 1 + ($random(seed) & 255);
    endfunction

    function automatic logic rand_bit();
        return ($random(seed) & 1) != 0;
    endfunction

    task automatic send_frame(input int n, input logic err);
        int   kept;
        int   base;
        logic drop_exp;
        kept = (n > 256) ? 256 : n;
        base = exp_data.size();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            in_byte  = 8'($random(seed));
            in_valid = 1'b1;
            bytes_sent++;
            if (i < 256) begin
                exp_data.push_back(in_byte);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_end   = 1'b1;
        in_err   = err;
        @(negedge clk);
        in_end   = 1'b0;
        in_err   = 1'b0;
        // with draining off the free blocks run from the write pointer up to the oldest frame
        drop_exp = !drain_en && (ring_used + blocks_of(kept) > 2**idx_width);
        if (drop_exp) begin
            exp_drops++;
        end else begin
            if (!drain_en) begin
                ring_used += blocks_of(kept);
            end
            exp_n_q.push_back(kept);
            exp_err_q.push_back(err || (n > 256));     // clipped frames are marked bad
            exp_base_q.push_back(base);
        end
        repeat (4) @(negedge clk);                      // drop lands 3 cycles after in_end
        check_count("drop_count", drop_cnt, exp_drops);
    endtask

    task automatic wait_drained();
        while (exp_n_q.size() != 0 || cur_n != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);                      // let the last release land
        ring_used = 0;
    endtask

    // compare every output word with the expected frame queue
    always @(negedge clk) begin
        if (reset_n && out_valid) begin
            if (cur_n == 0) begin
                if (exp_n_q.size() == 0) begin
                    $display("an output word arrived while no frame was expected");
                    err_cnt++;
                    stop_run();
                end else begin
                    cur_n    = exp_n_q.pop_front();
                    cur_err  = exp_err_q.pop_front();
                    cur_base = exp_base_q.pop_front();
                    cur_w    = 0;
                end
            end
            check_data("out_word.data", out_word.data, expected_word(cur_base, cur_n, cur_w));
            check_flag("out_word.first", out_word.first, cur_w == 0);
            check_flag("out_word.last", out_word.last, cur_w == (cur_n + 3) / 4 - 1);
            check_flag("out_word.err", out_word.err, cur_err);
            check_len("out_word.len", out_word.len, frame_len_t'(cur_n - 1));
            cur_w++;
            if (cur_w == (cur_n + 3) / 4) begin
                cur_n = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n && drop) begin
            drop_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 2000 + 200 * bytes_sent) begin
            $display("timeout: the run exceeded %0d cycles", cycle_cnt - 1);
            stop_run();
        end
    end

    initial begin
        seed     = 32'h4bcf;
        clk      = 1'b0;
        reset_n  = 1'b0;
        in_byte  = 8'h00;
        in_valid = 1'b0;
        in_end   = 1'b0;
        in_err   = 1'b0;
        flush    = 1'b0;
        drain_en = 1'b0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        repeat (4) @(negedge clk);

        // single frames around word and block edges
        drain_en = 1'b1;
        send_frame(1, 1'b0);
        send_frame(4, 1'b1);
        send_frame(5, 1'b0);
        send_frame(32, 1'b1);
        send_frame(33, 1'b0);
        send_frame(256, 1'b1);
        wait_drained();

        // random frames with draining on, enough bytes to wrap the ring
        for (int i = 0; i < 40; i++) begin
            send_frame(rand_len(), rand_bit());
        end
        wait_drained();

        // fill the ring with draining off, long frames first so drops are certain
        drain_en = 1'b0;
        for (int i = 0; i < 12; i++) begin
            send_frame(200 + ($random(seed) & 31), rand_bit());
        end
        for (int i = 0; i < 8; i++) begin
            send_frame(rand_len(), rand_bit());
        end
        drain_en = 1'b1;
        wait_drained();

        send_frame(300, 1'b0);                          // clipped to 256 bytes
        wait_drained();

        // pending frames are discarded by flush
        drain_en = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_frame(rand_len(), rand_bit());
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        exp_n_q.delete();
        exp_err_q.delete();
        exp_base_q.delete();
        ring_used = 0;
        drain_en  = 1'b1;
        repeat (40) @(negedge clk);                     // any word here is unexpected
        for (int i = 0; i < 3; i++) begin
            send_frame(rand_len(), rand_bit());
        end
        wait_drained();

        repeat (10) @(negedge clk);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire
